//--- include/mac_macros.svh
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

// operand width of a, b and c.
`define MAC_OPND_W 8

// slot tag width, also the result memory address width.
`define MAC_TAG_W 4

// number of peer engines behind the dispatcher.
`define MAC_NUM_ENG 2

// serial steps per operation, one per multiplier bit.
`define MAC_STEPS 8

// full result width, high byte plus low byte.
`define MAC_RES_W (2 * `MAC_OPND_W)

`endif

//--- source/mac_pkg.sv
`default_nettype none

`include "mac_macros.svh"

package mac_pkg;

   // ******************************
   // operation request
   // ******************************

   typedef struct packed {
      logic [`MAC_OPND_W-1:0] a;    // multiplier.
      logic [`MAC_OPND_W-1:0] b;    // multiplicand.
      logic [`MAC_OPND_W-1:0] c;    // addend.
      logic [`MAC_TAG_W-1:0]  tag;  // result slot.
   } mac_op_t;

   // ******************************
   // engine states
   // ******************************

   typedef enum logic [1:0] {
      eng_idle  = 2'd0,
      eng_run   = 2'd1,
      eng_write = 2'd2
   } eng_state_t;

endpackage

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

`include "mac_macros.svh"

package mem_pkg;

   // result slot address, same width as the operation tag.
   typedef logic [`MAC_TAG_W-1:0] slot_t;

   typedef struct packed {
      logic [`MAC_OPND_W-1:0] hi;
      logic [`MAC_OPND_W-1:0] lo;
   } result_bytes_t;

   // ******************************
   // stored result word
   // ******************************

   // engines write the whole product, the read port takes the byte halves.
   typedef union packed {
      logic [`MAC_RES_W-1:0] whole;
      result_bytes_t         bytes;
   } result_word_t;

endpackage

`default_nettype wire

//--- source/res_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface res_wr_if;

   logic                  valid;  // held until ready.
   logic                  ready;
   mem_pkg::slot_t        slot;
   mem_pkg::result_word_t data;

   modport engine (
      output valid,
      output slot,
      output data,
      input  ready
   );

   modport arbiter (
      input  valid,
      input  slot,
      input  data,
      output ready
   );

endinterface

`default_nettype wire

//--- source/serial_mac_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module serial_mac_engine (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             start,
   input  mac_pkg::mac_op_t op,
   output logic             busy,
   res_wr_if.engine         wr
);

   localparam int cnt_w = $clog2(`MAC_STEPS);
   localparam logic [cnt_w-1:0] last_step = cnt_w'(`MAC_STEPS - 1);

   mac_pkg::eng_state_t    state;
   logic [cnt_w-1:0]       step;

   logic [`MAC_OPND_W-1:0] mcand;
   logic [`MAC_OPND_W-1:0] mplier;
   logic [`MAC_OPND_W-1:0] acc_hi;
   logic [`MAC_OPND_W-1:0] acc_lo;
   logic [`MAC_TAG_W-1:0]  tag_q;
   logic [`MAC_OPND_W:0]   sum;
   mem_pkg::result_word_t  product;

   // ******************************
   // control
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= mac_pkg::eng_idle;
         step  <= '0;
      end else begin
         case (state)
            mac_pkg::eng_idle: begin
               if (start) begin
                  state <= mac_pkg::eng_run;
                  step  <= '0;
               end
            end
            mac_pkg::eng_run: begin
               step <= step + 1'b1;
               if (step == last_step) begin
                  state <= mac_pkg::eng_write;
               end
            end
            mac_pkg::eng_write: begin
               if (wr.ready) begin  // transfer.
                  state <= mac_pkg::eng_idle;
               end
            end
            default: state <= mac_pkg::eng_idle;
         endcase
      end
   end

   assign busy = (state != mac_pkg::eng_idle);

   // ******************************
   // shift-and-add datapath
   // ******************************

   // add b or zero to the high byte, carry lands in bit 8.
   assign sum = {1'b0, acc_hi} + (mplier[0] ? {1'b0, mcand} : '0);

   always_ff @(posedge clk) begin
      if (state == mac_pkg::eng_idle && start) begin
         mcand  <= op.b;
         mplier <= op.a;
         acc_hi <= op.c;  // addend preloaded, halved out over the steps.
         acc_lo <= '0;
         tag_q  <= op.tag;
      end else if (state == mac_pkg::eng_run) begin
         acc_hi <= sum[`MAC_OPND_W:1];
         acc_lo <= {sum[0], acc_lo[`MAC_OPND_W-1:1]};  // dropped bit into low byte.
         mplier <= mplier >> 1;
      end
   end

   assign product.whole = {acc_hi, acc_lo};

   assign wr.valid = (state == mac_pkg::eng_write);
   assign wr.slot  = tag_q;
   assign wr.data  = product;

endmodule

`default_nettype wire

//--- source/op_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module op_dispatch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  mac_pkg::mac_op_t        in_op,
   input  logic [`MAC_NUM_ENG-1:0] eng_busy,
   output logic [`MAC_NUM_ENG-1:0] eng_start,
   output mac_pkg::mac_op_t        eng_op
);

   localparam int idx_w = (`MAC_NUM_ENG > 1) ? $clog2(`MAC_NUM_ENG) : 1;

   logic [`MAC_NUM_ENG-1:0] idle;
   logic [idx_w-1:0]        sel_idx;
   logic                    any_idle;
   logic                    xfer;

   // busy rises on the start edge, so a started engine is never offered twice.
   assign idle = ~eng_busy;

   // priority encoder, lowest idle engine wins.
   always_comb begin
      any_idle = 1'b0;
      sel_idx  = '0;
      for (int i = `MAC_NUM_ENG - 1; i >= 0; i--) begin
         if (idle[i]) begin
            any_idle = 1'b1;
            sel_idx  = idx_w'(i);
         end
      end
   end

   assign in_ready = rst_n & any_idle;
   assign xfer     = in_valid & in_ready;

   always_comb begin
      eng_start = '0;
      if (xfer) eng_start[sel_idx] = 1'b1;
   end

   assign eng_op = in_op;  // the started engine alone latches the broadcast op.

endmodule

`default_nettype wire

//--- source/res_wr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module res_wr_arbiter (
   input  logic                  clk,
   input  logic                  rst_n,
   res_wr_if.arbiter             req [`MAC_NUM_ENG],
   output logic                  mem_we,
   output mem_pkg::slot_t        mem_slot,
   output mem_pkg::result_word_t mem_data,
   output logic                  done_valid,
   output mem_pkg::slot_t        done_tag
);

   localparam int idx_w = (`MAC_NUM_ENG > 1) ? $clog2(`MAC_NUM_ENG) : 1;

   logic [`MAC_NUM_ENG-1:0] req_v;
   logic [`MAC_NUM_ENG-1:0] gnt;
   mem_pkg::slot_t          req_slot [`MAC_NUM_ENG];
   mem_pkg::result_word_t   req_data [`MAC_NUM_ENG];
   logic [idx_w-1:0]        last_q;
   logic [idx_w-1:0]        gnt_idx;

   // flatten the interface array so it can be indexed at run time.
   for (genvar g = 0; g < `MAC_NUM_ENG; g++) begin : g_flat
      assign req_v[g]     = req[g].valid;
      assign req_slot[g]  = req[g].slot;
      assign req_data[g]  = req[g].data;
      assign req[g].ready = gnt[g];
   end

   // ******************************
   // round-robin grant
   // ******************************

   always_comb begin
      int   idx;
      logic found;
      gnt     = '0;
      gnt_idx = last_q;
      found   = 1'b0;
      for (int i = 1; i <= `MAC_NUM_ENG; i++) begin
         idx = int'(last_q) + i;  // search starts past the last grant.
         if (idx >= `MAC_NUM_ENG) idx = idx - `MAC_NUM_ENG;
         if (req_v[idx] && !found) begin
            found    = 1'b1;
            gnt[idx] = 1'b1;
            gnt_idx  = idx_w'(idx);
         end
      end
   end

   assign mem_we   = |gnt;
   assign mem_slot = req_slot[gnt_idx];
   assign mem_data = req_data[gnt_idx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_q     <= idx_w'(`MAC_NUM_ENG - 1);  // engine 0 first after reset.
         done_valid <= 1'b0;
      end else begin
         done_valid <= mem_we;
         if (mem_we) last_q <= gnt_idx;
      end
   end

   // tag follows the write into memory.
   always_ff @(posedge clk) begin
      if (mem_we) done_tag <= mem_slot;
   end

endmodule

`default_nettype wire

//--- source/result_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module result_mem (
   input  logic                   clk,
   input  logic                   we,
   input  mem_pkg::slot_t         wr_slot,
   input  mem_pkg::result_word_t  wr_data,
   input  mem_pkg::slot_t         rd_addr,
   output logic [`MAC_OPND_W-1:0] rd_hi,
   output logic [`MAC_OPND_W-1:0] rd_lo
);

   localparam int depth = 1 << `MAC_TAG_W;

   mem_pkg::result_word_t mem [depth];
   mem_pkg::result_word_t rd_q;

   // ******************************
   // write port
   // ******************************

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_slot] <= wr_data;
      end
   end

   // ******************************
   // read port
   // ******************************

   always_ff @(posedge clk) begin
      rd_q <= mem[rd_addr];  // one cycle read latency.
   end

   // byte view of the stored word.
   assign rd_hi = rd_q.bytes.hi;
   assign rd_lo = rd_q.bytes.lo;

endmodule

`default_nettype wire

//--- source/mac_cluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module mac_cluster (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  logic [`MAC_OPND_W-1:0] a,
   input  logic [`MAC_OPND_W-1:0] b,
   input  logic [`MAC_OPND_W-1:0] c,
   input  logic [`MAC_TAG_W-1:0]  tag,
   output logic                   done_valid,
   output mem_pkg::slot_t         done_tag,
   input  mem_pkg::slot_t         rd_addr,
   output logic [`MAC_OPND_W-1:0] rd_hi,
   output logic [`MAC_OPND_W-1:0] rd_lo
);

   mac_pkg::mac_op_t        in_op;
   mac_pkg::mac_op_t        eng_op;
   logic [`MAC_NUM_ENG-1:0] eng_busy;
   logic [`MAC_NUM_ENG-1:0] eng_start;
   logic                    mem_we;
   mem_pkg::slot_t          mem_slot;
   mem_pkg::result_word_t   mem_data;

   assign in_op = '{a: a, b: b, c: c, tag: tag};

   op_dispatch u_dispatch (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_op     (in_op),
      .eng_busy  (eng_busy),
      .eng_start (eng_start),
      .eng_op    (eng_op)
   );

   // ******************************
   // engines and write buses
   // ******************************

   res_wr_if wr_bus [`MAC_NUM_ENG] ();

   for (genvar g = 0; g < `MAC_NUM_ENG; g++) begin : g_eng
      serial_mac_engine u_eng (
         .clk   (clk),
         .rst_n (rst_n),
         .start (eng_start[g]),
         .op    (eng_op),
         .busy  (eng_busy[g]),
         .wr    (wr_bus[g].engine)
      );
   end

   res_wr_arbiter u_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (wr_bus),
      .mem_we     (mem_we),
      .mem_slot   (mem_slot),
      .mem_data   (mem_data),
      .done_valid (done_valid),
      .done_tag   (done_tag)
   );

   result_mem u_mem (
      .clk     (clk),
      .we      (mem_we),
      .wr_slot (mem_slot),
      .wr_data (mem_data),
      .rd_addr (rd_addr),
      .rd_hi   (rd_hi),
      .rd_lo   (rd_lo)
   );

endmodule

`default_nettype wire

//--- testbench/tb_mac_cluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module tb_mac_cluster;

   localparam int num_slots  = 1 << `MAC_TAG_W;
   localparam int b2b_ops    = 24;
   localparam int stream_ops = 200;
   localparam int num_ops    = 1 + 8 + b2b_ops + stream_ops;
   localparam int limit_cyc  = num_ops * 40 + 200;

   logic                   clk;
   logic                   rst_n;
   logic                   in_valid;
   logic                   in_ready;
   logic [`MAC_OPND_W-1:0] a;
   logic [`MAC_OPND_W-1:0] b;
   logic [`MAC_OPND_W-1:0] c;
   logic [`MAC_TAG_W-1:0]  tag;
   logic                   done_valid;
   mem_pkg::slot_t         done_tag;
   mem_pkg::slot_t         rd_addr;
   logic [`MAC_OPND_W-1:0] rd_hi;
   logic [`MAC_OPND_W-1:0] rd_lo;

   integer                 seed;

   // ******************************
   // reference model
   // ******************************

   mem_pkg::result_word_t  expected [num_slots];
   logic [num_slots-1:0]   pending;    // issued and not yet read back.
   logic [num_slots-1:0]   done_seen;
   int                     done_count;
   string                  test_name;
   mem_pkg::slot_t         rd_queue [$];
   logic                   rd_active;
   mem_pkg::slot_t         rd_slot;

   mac_cluster dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .a          (a),
      .b          (b),
      .c          (c),
      .tag        (tag),
      .done_valid (done_valid),
      .done_tag   (done_tag),
      .rd_addr    (rd_addr),
      .rd_hi      (rd_hi),
      .rd_lo      (rd_lo)
   );

   always #4 clk = ~clk;

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input mem_pkg::result_word_t exp,
                             input mem_pkg::result_word_t act);
      if (act !== exp) begin
         report_failure($sformatf("mismatch in %s: expected %h, actual %h",
                                  name, exp.whole, act.whole));
      end
   endtask

   task automatic check_tag(input string name, input mem_pkg::slot_t exp,
                            input mem_pkg::slot_t act);
      if (act !== exp) begin
         report_failure($sformatf("mismatch in %s: expected tag %h, actual tag %h",
                                  name, exp, act));
      end
   endtask

   // every done pulse must hit a slot that is waiting for its write.
   task automatic watch_done();
      if (done_valid) begin
         if (!pending[done_tag] || done_seen[done_tag]) begin
            report_failure($sformatf("done pulse for slot %0d, which had no write outstanding",
                                     done_tag));
         end
         done_seen[done_tag] = 1'b1;
         done_count++;
         rd_queue.push_back(done_tag);
      end
   endtask

   task automatic service_read();
      mem_pkg::result_word_t got;
      if (rd_active) begin
         got.bytes.hi = rd_hi;  // address went out one edge ago.
         got.bytes.lo = rd_lo;
         check_word(test_name, expected[rd_slot], got);
         pending[rd_slot]   = 1'b0;
         done_seen[rd_slot] = 1'b0;
         rd_active          = 1'b0;
      end
      if (rd_queue.size() > 0) begin
         rd_slot   = rd_queue.pop_front();
         rd_addr   = rd_slot;
         rd_active = 1'b1;
      end
   endtask

   task automatic tick();
      @(negedge clk);
      watch_done();
      service_read();
   endtask

   task automatic pick_slot(output mem_pkg::slot_t s);
      integer r;
      while (&pending) tick();
      r = $random(seed);
      s = r[`MAC_TAG_W-1:0];
      while (pending[s]) s = s + 1'b1;  // step to the next free slot with wraparound.
   endtask

   task automatic rand_op(output mac_pkg::mac_op_t op);
      integer         r;
      mem_pkg::slot_t s;
      r = $random(seed);
      pick_slot(s);
      op.a   = r[7:0];
      op.b   = r[15:8];
      op.c   = r[23:16];
      op.tag = s;
   endtask

   task automatic issue_op(input mac_pkg::mac_op_t op);
      logic [15:0] exp_val;
      in_valid = 1'b1;
      a        = op.a;
      b        = op.b;
      c        = op.c;
      tag      = op.tag;
      while (!in_ready) tick();
      exp_val = {8'd0, op.a} * {8'd0, op.b} + {8'd0, op.c};
      expected[op.tag].whole = exp_val;
      pending[op.tag] = 1'b1;
      tick();  // accepted on this edge.
      in_valid = 1'b0;
   endtask

   task automatic await_done(input mem_pkg::slot_t t);
      int seen;
      seen = done_count;
      while (done_count == seen) begin
         @(negedge clk);
         if (done_valid) check_tag(test_name, t, done_tag);
         watch_done();
         service_read();
      end
   endtask

   task automatic drain();
      while (pending != '0) tick();
   endtask

   // ******************************
   // stimulus
   // ******************************

   initial begin
      mac_pkg::mac_op_t op;
      mem_pkg::slot_t   s;
      integer           r;
      clk        = 1'b0;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      a          = '0;
      b          = '0;
      c          = '0;
      tag        = '0;
      rd_addr    = '0;
      seed       = 32'hb626_8147;
      pending    = '0;
      done_seen  = '0;
      done_count = 0;
      rd_active  = 1'b0;
      test_name  = "reset";

      repeat (3) begin
         @(negedge clk);
         if (in_ready !== 1'b0) report_failure("in_ready is high while reset is asserted");
      end
      rst_n = 1'b1;
      tick();
      if (done_valid !== 1'b0) report_failure("done_valid is not low after reset");
      if (in_ready !== 1'b1) report_failure("in_ready is not high after reset");
      if (dut0.g_eng[0].u_eng.state != mac_pkg::eng_idle ||
          dut0.g_eng[1].u_eng.state != mac_pkg::eng_idle) begin
         report_failure("an engine is not idle after reset");
      end

      test_name = "single";
      rand_op(op);
      issue_op(op);
      await_done(op.tag);
      drain();

      test_name = "corners";
      for (int i = 0; i < 8; i++) begin
         pick_slot(s);
         op.a   = i[2] ? 8'hff : 8'h00;
         op.b   = i[1] ? 8'hff : 8'h00;
         op.c   = i[0] ? 8'hff : 8'h00;
         op.tag = s;
         issue_op(op);
         await_done(op.tag);
         drain();
      end

      // consecutive issue keeps both engines busy.
      test_name = "back_to_back";
      repeat (b2b_ops) begin
         rand_op(op);
         issue_op(op);
      end
      drain();

      test_name = "stream";
      repeat (stream_ops) begin
         r = $random(seed);
         if (r[2:0] == 3'd0) repeat (r[4:3] + 1) tick();  // idle gap.
         rand_op(op);
         issue_op(op);
      end
      drain();

      // no stray done pulses once every slot is read back.
      repeat (16) tick();

      $display("Simulation PASSED");
      $finish;
   end

   // watchdog.
   initial begin
      repeat (limit_cyc) @(posedge clk);
      report_failure($sformatf("timeout: run did not finish within %0d cycles", limit_cyc));
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
source/mac_pkg.sv
source/mem_pkg.sv
source/res_wr_if.sv
source/serial_mac_engine.sv
source/op_dispatch.sv
source/res_wr_arbiter.sv
source/result_mem.sv
source/mac_cluster.sv
testbench/tb_mac_cluster.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mac_cluster testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_mac_cluster -o sim_tb

# the simulator status is not trusted, the log decides.
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
exit 0
